/* files.f */
+incdir+include
logic/noc_pkg.sv
logic/flit_if.sv
logic/pkt_injector.sv
logic/flit_fifo.sv
logic/flit_router.sv
logic/pe_node.sv
logic/noc_loaded.sv
tests/noc_checker.sv
tests/tb_noc_loaded.sv

/* include/noc_defs.svh */
`ifndef NOC_DEFS_SVH
`define NOC_DEFS_SVH

// Default widths for the top level
`define NOC_DATAW 32
`define NOC_FIFOD 4

`endif

/* logic/flit_fifo.sv */
`timescale 1ns/100ps

module flit_fifo #(
    parameter int DEPTH = 4
) (
    input  logic           clk,
    input  logic           rst,
    input  logic           wr_en,
    input  noc_pkg::flit_t wr_flit,
    input  logic           rd_en,
    output noc_pkg::flit_t rd_flit,
    output logic           full,
    output logic           empty
);
    import noc_pkg::*;

    localparam int AW = $clog2(DEPTH);

    flit_t       mem [DEPTH];
    logic [AW:0] wr_ptr;
    logic [AW:0] rd_ptr;
    logic [AW:0] rd_ptr_nxt;
    logic        do_wr;
    logic        do_rd;

    // Extra pointer bit separates full from empty
    assign empty = (wr_ptr == rd_ptr);
    assign full  = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);

    assign do_wr      = wr_en && !full;
    assign do_rd      = rd_en && !empty;
    assign rd_ptr_nxt = rd_ptr + {{AW{1'b0}}, do_rd};

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr <= wr_ptr + {{AW{1'b0}}, 1'b1};
            end
            rd_ptr <= rd_ptr_nxt;
        end
    end

    always_ff @(posedge clk) begin
        if (do_wr) begin
            mem[wr_ptr[AW-1:0]] <= wr_flit;
        end
    end

    // New word goes straight into the head register when it becomes the head
    always_ff @(posedge clk) begin
        if (do_wr && (wr_ptr == rd_ptr_nxt)) begin
            rd_flit <= wr_flit;
        end else begin
            rd_flit <= mem[rd_ptr_nxt[AW-1:0]];
        end
    end

endmodule

/* logic/flit_if.sv */
`timescale 1ns/100ps

interface flit_if;
    import noc_pkg::*;

    logic  valid;
    logic  ready;
    flit_t flit;

    modport tx (output valid, output flit, input ready);
    modport rx (input valid, input flit, output ready);

endinterface

/* logic/flit_router.sv */
`timescale 1ns/100ps

module flit_router #(
    parameter int FIFOD = 4
) (
    input  logic           clk,
    input  logic           rst,
    flit_if.rx             inj,
    flit_if.tx             to_pe   [noc_pkg::NODES],
    flit_if.rx             from_pe [noc_pkg::NODES],
    output logic           m_valid,
    input  logic           m_ready,
    output noc_pkg::flit_t m_flit
);
    import noc_pkg::*;

    logic [NODES-1:0] ob_wr;
    logic [NODES-1:0] ob_rd;
    logic [NODES-1:0] ob_full;
    logic [NODES-1:0] ob_empty;
    flit_t            ob_head [NODES];
    logic [NODES-1:0] rt_wr;
    logic [NODES-1:0] rt_rd;
    logic [NODES-1:0] rt_full;
    logic [NODES-1:0] rt_empty;
    flit_t            rt_head [NODES];
    logic [NODEW-1:0] rr_ptr;
    logic [NODEW-1:0] grant;
    logic             grant_vld;
    logic             load;

    // Stall on the head flit's destination, head-of-line blocking
    assign inj.ready = !ob_full[inj.flit.node];

    for (genvar i = 0; i < NODES; i++) begin : g_node
        // ------------------------------
        // Outbound path to PE i
        // ------------------------------
        assign ob_wr[i]       = inj.valid && inj.ready && (inj.flit.node == NODEW'(i));
        assign ob_rd[i]       = to_pe[i].valid && to_pe[i].ready;
        assign to_pe[i].valid = !ob_empty[i];
        assign to_pe[i].flit  = ob_head[i];

        flit_fifo #(
            .DEPTH (FIFOD)
        ) u_ob_fifo (
            .clk     (clk),
            .rst     (rst),
            .wr_en   (ob_wr[i]),
            .wr_flit (inj.flit),
            .rd_en   (ob_rd[i]),
            .rd_flit (ob_head[i]),
            .full    (ob_full[i]),
            .empty   (ob_empty[i])
        );

        // ------------------------------
        // Return path from PE i
        // ------------------------------
        assign from_pe[i].ready = !rt_full[i];
        assign rt_wr[i]         = from_pe[i].valid && from_pe[i].ready;
        assign rt_rd[i]         = load && grant_vld && (grant == NODEW'(i));

        flit_fifo #(
            .DEPTH (FIFOD)
        ) u_rt_fifo (
            .clk     (clk),
            .rst     (rst),
            .wr_en   (rt_wr[i]),
            .wr_flit (from_pe[i].flit),
            .rd_en   (rt_rd[i]),
            .rd_flit (rt_head[i]),
            .full    (rt_full[i]),
            .empty   (rt_empty[i])
        );
    end

    // Output slot free or draining
    assign load = !m_valid || m_ready;

    // Round-robin pick, first non-empty FIFO at or after the pointer
    always_comb begin
        logic [NODEW-1:0] idx;
        grant_vld = 1'b0;
        grant     = rr_ptr;
        for (int k = NODES - 1; k >= 0; k--) begin
            idx = rr_ptr + NODEW'(k);
            if (!rt_empty[idx]) begin
                grant_vld = 1'b1;
                grant     = idx;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            m_valid <= 1'b0;
            rr_ptr  <= '0;
        end else if (load) begin
            m_valid <= grant_vld;
            if (grant_vld) begin
                rr_ptr <= grant + NODEW'(1);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (load && grant_vld) begin
            m_flit <= rt_head[grant];
        end
    end

endmodule

/* logic/noc_loaded.sv */
`timescale 1ns/100ps
`include "noc_defs.svh"

module noc_loaded #(
    parameter int DATAW = `NOC_DATAW,
    parameter int FIFOD = `NOC_FIFOD
) (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      s_valid,
    output logic                      s_ready,
    input  logic [DATAW-1:0]          s_data,
    input  noc_pkg::opcode_e          s_op,
    input  logic [noc_pkg::NODEW-1:0] s_node,
    input  logic [noc_pkg::TAGW-1:0]  s_tag,
    output logic                      m_valid,
    input  logic                      m_ready,
    output logic [DATAW-1:0]          m_data,
    output logic [noc_pkg::NODEW-1:0] m_node,
    output logic [noc_pkg::TAGW-1:0]  m_tag
);
    import noc_pkg::*;

    flit_t m_flit;

    flit_if inj ();
    flit_if to_pe   [NODES] ();
    flit_if from_pe [NODES] ();

    pkt_injector #(
        .DATAW (DATAW)
    ) u_injector (
        .clk     (clk),
        .rst     (rst),
        .s_valid (s_valid),
        .s_ready (s_ready),
        .s_data  (s_data),
        .s_op    (s_op),
        .s_node  (s_node),
        .s_tag   (s_tag),
        .out     (inj)
    );

    flit_router #(
        .FIFOD (FIFOD)
    ) u_router (
        .clk     (clk),
        .rst     (rst),
        .inj     (inj),
        .to_pe   (to_pe),
        .from_pe (from_pe),
        .m_valid (m_valid),
        .m_ready (m_ready),
        .m_flit  (m_flit)
    );

    // One compute node per router port
    for (genvar i = 0; i < NODES; i++) begin : g_pe
        pe_node #(
            .DATAW   (DATAW),
            .NODE_ID (i)
        ) u_pe (
            .clk (clk),
            .rst (rst),
            .in  (to_pe[i]),
            .out (from_pe[i])
        );
    end

    // Result fields out, node is the source PE
    assign m_data = m_flit.data;
    assign m_node = m_flit.node;
    assign m_tag  = m_flit.tag;

endmodule

/* logic/noc_pkg.sv */
package noc_pkg;

    localparam int NODES = 4;
    localparam int NODEW = 2;
    localparam int TAGW  = 8;

    // PE operations
    typedef enum logic [1:0] {
        OP_PASS     = 2'd0,
        OP_RELU     = 2'd1,
        OP_NEG      = 2'd2,
        OP_ADD_NODE = 2'd3
    } opcode_e;

    // Node is the destination outbound, the source PE on return
    typedef struct packed {
        opcode_e            op;
        logic [NODEW-1:0]   node;
        logic [TAGW-1:0]    tag;
        logic signed [31:0] data;
    } flit_t;

endpackage

/* logic/pe_node.sv */
`timescale 1ns/100ps

module pe_node #(
    parameter int DATAW   = 32,
    parameter int NODE_ID = 0
) (
    input logic clk,
    input logic rst,
    flit_if.rx  in,
    flit_if.tx  out
);
    import noc_pkg::*;

    logic                    advance;
    logic                    s1_valid;
    flit_t                   s1_flit;
    logic                    s1_clamp;
    logic                    s2_valid;
    flit_t                   s2_flit;
    logic signed [DATAW-1:0] result;

    // Whole pipe moves together
    assign advance  = !s2_valid || out.ready;
    assign in.ready = advance;

    always_ff @(posedge clk) begin
        if (rst) begin
            s1_valid <= 1'b0;
            s2_valid <= 1'b0;
        end else if (advance) begin
            s1_valid <= in.valid;
            s2_valid <= s1_valid;
        end
    end

    // Stage two operation
    always_comb begin
        case (s1_flit.op)
            OP_PASS:     result = s1_flit.data;
            OP_RELU:     result = s1_clamp ? '0 : s1_flit.data;
            OP_NEG:      result = -s1_flit.data;
            OP_ADD_NODE: result = s1_flit.data + DATAW'(NODE_ID);
            default:     result = s1_flit.data;
        endcase
    end

    always_ff @(posedge clk) begin
        if (advance) begin
            s1_flit      <= in.flit;
            // ReLU of a negative word
            s1_clamp     <= (in.flit.op == OP_RELU) && in.flit.data[DATAW-1];
            s2_flit.op   <= s1_flit.op;
            s2_flit.node <= NODEW'(NODE_ID);
            s2_flit.tag  <= s1_flit.tag;
            s2_flit.data <= result;
        end
    end

    assign out.valid = s2_valid;
    assign out.flit  = s2_flit;

endmodule

/* logic/pkt_injector.sv */
`timescale 1ns/100ps

module pkt_injector #(
    parameter int DATAW = 32
) (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      s_valid,
    output logic                      s_ready,
    input  logic [DATAW-1:0]          s_data,
    input  noc_pkg::opcode_e          s_op,
    input  logic [noc_pkg::NODEW-1:0] s_node,
    input  logic [noc_pkg::TAGW-1:0]  s_tag,
    flit_if.tx                        out
);
    import noc_pkg::*;

    logic  full_q;
    flit_t flit_q;

    // Free slot, or the held flit leaves this cycle
    assign s_ready = !full_q || out.ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            full_q <= 1'b0;
        end else if (s_ready) begin
            full_q <= s_valid;
        end
    end

    // Pack host fields into the flit register
    always_ff @(posedge clk) begin
        if (s_valid && s_ready) begin
            flit_q.op   <= s_op;
            flit_q.node <= s_node;
            flit_q.tag  <= s_tag;
            flit_q.data <= s_data;
        end
    end

    assign out.valid = full_q;
    assign out.flit  = flit_q;

endmodule

/* run_sim.sh */
#!/bin/sh
# Build and run the NoC testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --top-module tb_noc_loaded -f files.f -o sim_noc > build.log 2>&1 \
    && ./obj_dir/sim_noc > sim.log 2>&1 \
    || { cat build.log sim.log 2>/dev/null; echo "Build or simulation did not complete"; exit 1; }
cat sim.log
grep -q "Verification failed" sim.log && exit 1
grep -q "Verification passed" sim.log || exit 1

/* tests/noc_checker.sv */
`timescale 1ns/100ps

module noc_checker (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      s_valid,
    input  logic                      s_ready,
    input  logic [31:0]               s_data,
    input  noc_pkg::opcode_e          s_op,
    input  logic [noc_pkg::NODEW-1:0] s_node,
    input  logic [noc_pkg::TAGW-1:0]  s_tag,
    input  logic                      m_valid,
    input  logic                      m_ready,
    input  logic [31:0]               m_data,
    input  logic [noc_pkg::NODEW-1:0] m_node,
    input  logic [noc_pkg::TAGW-1:0]  m_tag,
    input  logic                      test_end,
    input  int                        test_id,
    output int                        pending,
    output int                        checked,
    output int                        errors
);
    import noc_pkg::*;

    localparam int NTAGS = 1 << TAGW;

    logic               outstanding [NTAGS];
    logic signed [31:0] exp_data    [NTAGS];
    logic [NODEW-1:0]   exp_node    [NTAGS];
    logic               rst_q;
    logic               stall_seen;
    int                 test_checked;
    int                 test_errors;

    // Expected PE result, node is the PE index
    function automatic logic signed [31:0] ref_result(input opcode_e op,
                                                      input logic [NODEW-1:0] node,
                                                      input logic signed [31:0] d);
        case (op)
            OP_PASS:     return d;
            OP_RELU:     return (d < 0) ? 32'sd0 : d;
            OP_NEG:      return -d;
            OP_ADD_NODE: return d + 32'(node);
            default:     return d;
        endcase
    endfunction

    function automatic string test_name(input int id);
        case (id)
            1:       return "reset state";
            2:       return "each opcode on each node";
            3:       return "random traffic";
            4:       return "back-pressure";
            default: return "hot spot and fairness";
        endcase
    endfunction

    task automatic report_error(input bit wrong_value, input string msg);
        errors++;
        test_errors++;
        if (wrong_value) begin
            $display("[FAIL] %0t ns: %s", $time, msg);
        end else begin
            $display("Error at %0t ns: %s", $time, msg);
        end
    endtask

    initial begin
        pending      = 0;
        checked      = 0;
        errors       = 0;
        test_checked = 0;
        test_errors  = 0;
        rst_q        = 1'b1;
        stall_seen   = 1'b0;
        for (int t = 0; t < NTAGS; t++) begin
            outstanding[t] = 1'b0;
        end
    end

    always @(posedge clk) begin
        if (rst) begin
            if (m_valid === 1'b1) begin
                report_error(1'b1, "m_valid is high during reset");
            end
        end else begin
            if (rst_q && (s_ready !== 1'b1 || m_valid !== 1'b0)) begin
                report_error(1'b1, "s_ready low or m_valid high right after reset");
            end
            if (!m_ready && !s_ready) begin
                stall_seen = 1'b1;
            end
            // Host side, remember the expected result under its tag
            if (s_valid && s_ready) begin
                if (outstanding[s_tag]) begin
                    report_error(1'b0, $sformatf("tag %0d was issued again before it returned",
                                                 s_tag));
                end else begin
                    outstanding[s_tag] = 1'b1;
                    exp_data[s_tag]    = ref_result(s_op, s_node, s_data);
                    exp_node[s_tag]    = s_node;
                    pending++;
                end
            end
            // Output side
            if (m_valid && m_ready) begin
                if (!outstanding[m_tag]) begin
                    report_error(1'b0, $sformatf("result with tag %0d was not expected", m_tag));
                end else begin
                    if (m_data !== exp_data[m_tag]) begin
                        report_error(1'b1, $sformatf("tag %0d data %0d, expected %0d", m_tag,
                                                     $signed(m_data), exp_data[m_tag]));
                    end
                    if (m_node !== exp_node[m_tag]) begin
                        report_error(1'b1, $sformatf("tag %0d from node %0d, expected %0d",
                                                     m_tag, m_node, exp_node[m_tag]));
                    end
                    outstanding[m_tag] = 1'b0;
                    pending--;
                    checked++;
                    test_checked++;
                end
            end
            if (test_end) begin
                if (test_id == 4 && !stall_seen) begin
                    report_error(1'b0, "s_ready never dropped while m_ready was low");
                end
                $display("Test %0d, %s: %0d results checked, %0d errors", test_id,
                         test_name(test_id), test_checked, test_errors);
                test_checked = 0;
                test_errors  = 0;
                stall_seen   = 1'b0;
            end
        end
        rst_q = rst;
    end

endmodule

/* tests/tb_noc_loaded.sv */
`timescale 1ns/100ps

module tb_noc_loaded;
    import noc_pkg::*;

    // 40 cycles per packet plus slack for reset and drains
    localparam int NPKTS = 16 + 200 + 200 + 128;
    localparam int LIMIT = 40 * NPKTS + 200;

    logic             clk;
    logic             rst;
    logic             s_valid;
    logic             s_ready;
    logic [31:0]      s_data;
    opcode_e          s_op;
    logic [NODEW-1:0] s_node;
    logic [TAGW-1:0]  s_tag;
    logic             m_valid;
    logic             m_ready;
    logic [31:0]      m_data;
    logic [NODEW-1:0] m_node;
    logic [TAGW-1:0]  m_tag;
    logic             test_end;
    int               test_id;
    int               pending;
    int               checked;
    int               errors;
    int               issued;
    int               cycles;
    int               hold;
    logic             bp_mode;
    integer           seed = 84907;

    noc_loaded #(
        .DATAW (32),
        .FIFOD (4)
    ) u_noc_loaded (.*);

    noc_checker u_checker (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    initial begin
        cycles = 0;
        while (cycles < LIMIT) begin
            @(posedge clk);
            cycles++;
        end
        $display("Timeout: run stopped after %0d cycles, %0d results outstanding",
                 cycles, pending);
        $display("Verification failed");
        $finish;
    end

    // ------------------------------
    // Output back-pressure
    // ------------------------------
    // Long low stretches and short high ones
    initial begin
        logic bp_now;
        hold = 0;
        forever begin
            @(posedge clk);
            // Mode is read on the edge before the stimulus changes it
            bp_now = bp_mode;
            #1;
            if (!bp_now) begin
                m_ready = 1'b1;
            end else if (hold > 0) begin
                hold--;
            end else begin
                m_ready = !m_ready;
                hold    = m_ready ? 2 + ($unsigned($random(seed)) % 8)
                                  : 20 + ($unsigned($random(seed)) % 40);
            end
        end
    end

    // ------------------------------
    // Stimulus
    // ------------------------------
    task automatic send_pkt(input opcode_e op, input logic [NODEW-1:0] node,
                            input logic [31:0] data);
        logic taken;
        s_valid = 1'b1;
        s_op    = op;
        s_node  = node;
        s_data  = data;
        s_tag   = TAGW'(issued);
        taken   = 1'b0;
        while (!taken) begin
            @(negedge clk);
            taken = s_ready;
            @(posedge clk);
            #1;
        end
        s_valid = 1'b0;
        issued++;
    endtask

    // Negative fixed_node picks a random destination
    task automatic send_random(input int count, input int fixed_node);
        logic [1:0]       op;
        logic [NODEW-1:0] node;
        for (int i = 0; i < count; i++) begin
            op   = 2'($random(seed));
            node = (fixed_node < 0) ? NODEW'($random(seed)) : NODEW'(fixed_node);
            send_pkt(opcode_e'(op), node, $random(seed));
        end
    endtask

    task automatic end_test(input int id);
        bp_mode = 1'b0;
        while (pending != 0) begin
            @(negedge clk);
        end
        @(posedge clk);
        #1;
        test_id  = id;
        test_end = 1'b1;
        @(posedge clk);
        #1;
        test_end = 1'b0;
    endtask

    initial begin
        logic [31:0] word;
        rst      = 1'b1;
        s_valid  = 1'b0;
        s_data   = '0;
        s_op     = OP_PASS;
        s_node   = '0;
        s_tag    = '0;
        m_ready  = 1'b1;
        bp_mode  = 1'b0;
        test_end = 1'b0;
        test_id  = 0;
        issued   = 0;
        repeat (4) @(posedge clk);
        #1;
        rst = 1'b0;
        end_test(1);

        // Every opcode on every node with positive, negative and zero words
        for (int n = 0; n < NODES; n++) begin
            for (int k = 0; k < 4; k++) begin
                if ((n + k) % 3 == 0) begin
                    word = 32'(1000 + 16 * n + k);
                end else if ((n + k) % 3 == 1) begin
                    word = 32'(-(700 + 16 * n + k));
                end else begin
                    word = '0;
                end
                send_pkt(opcode_e'(2'(k)), NODEW'(n), word);
            end
        end
        end_test(2);

        send_random(200, -1);
        end_test(3);

        bp_mode = 1'b1;
        send_random(200, -1);
        end_test(4);

        // Hot spot on node 2 followed by spread traffic
        send_random(64, 2);
        send_random(64, -1);
        end_test(5);

        $display("5 tests, %0d packets issued, %0d results checked, %0d errors",
                 issued, checked, errors);
        if (errors == 0 && checked == issued) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule
